//--- compile.f
logic/spi_pkg.sv
logic/spi_pin_sync.sv
logic/spi_shift_engine.sv
logic/spi_word_fifo.sv
logic/spi_reg_if.sv
logic/spi_slave_top.sv
sim/spi_chk.sv
sim/spi_tb_monitor.sv
sim/spi_tb.sv

//--- logic/spi_pin_sync.sv
module spi_pin_sync (
   input  logic clk,
   input  logic rst,
   input  logic sclk,
   input  logic ss,
   input  logic mosi,
   output logic sclk_rise,
   output logic sclk_fall,
   output logic ss_fall,
   output logic ss_rise,
   output logic ss_act,
   output logic mosi_s
);

   // first and second synchronizer stages
   logic sclk_m, sclk_q;
   logic ss_m, ss_q;
   logic mosi_m;

   // levels seen one cycle earlier, for edge detect
   logic sclk_prev;
   logic ss_prev;

   always_ff @(posedge clk) begin
      if (!rst) begin
         sclk_m    <= 1'b0;
         sclk_q    <= 1'b0;
         // ss idles high, so no false select after reset
         ss_m      <= 1'b1;
         ss_q      <= 1'b1;
         mosi_m    <= 1'b0;
         mosi_s    <= 1'b0;
         sclk_prev <= 1'b0;
         ss_prev   <= 1'b1;
         sclk_rise <= 1'b0;
         sclk_fall <= 1'b0;
         ss_fall   <= 1'b0;
         ss_rise   <= 1'b0;
         ss_act    <= 1'b0;
      end else begin
         sclk_m    <= sclk;
         sclk_q    <= sclk_m;
         ss_m      <= ss;
         ss_q      <= ss_m;
         mosi_m    <= mosi;
         mosi_s    <= mosi_m;
         sclk_prev <= sclk_q;
         ss_prev   <= ss_q;
         // registered pulses, third cycle after the pin moves
         sclk_rise <= sclk_q & ~sclk_prev;
         sclk_fall <= ~sclk_q & sclk_prev;
         ss_fall   <= ~ss_q & ss_prev;
         ss_rise   <= ss_q & ~ss_prev;
         // select level lines up with the ss edge pulses
         ss_act    <= ~ss_q;
      end
   end

endmodule

//--- logic/spi_pkg.sv
package spi_pkg;

   // word width for spi frames and host data
   localparam int data_w = 8;

   // host register address width
   localparam int addr_w = 2;

   // register map
   // status, read only
   localparam logic [addr_w-1:0] reg_status = 2'd0;
   // write pushes one word into tx
   localparam logic [addr_w-1:0] reg_tx = 2'd1;
   // read pops one word from rx
   localparam logic [addr_w-1:0] reg_rx = 2'd2;
   // bit 0 written as 1 clears overrun
   localparam logic [addr_w-1:0] reg_ctrl = 2'd3;

   // status word bit positions
   // rx fifo holds at least one word
   localparam int st_rx_valid = 0;
   localparam int st_tx_full = 1;
   // sticky until cleared through reg_ctrl
   localparam int st_overrun = 2;
   // slave select currently low
   localparam int st_ss_active = 3;

   // fifo payloads
   // one received word per entry
   typedef logic [data_w-1:0] rx_item_t;
   // one word queued for miso
   typedef logic [data_w-1:0] tx_item_t;

endpackage

//--- logic/spi_reg_if.sv
module spi_reg_if #(
   parameter int DATA_W = spi_pkg::data_w
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [spi_pkg::addr_w-1:0] address,
   input  logic                      sel,
   input  logic                      we,
   input  logic [DATA_W-1:0]         data_in,
   input  logic [DATA_W-1:0]         rx_head,
   input  logic                      rx_empty,
   input  logic                      tx_full,
   input  logic                      ss_act,
   input  logic                      rx_drop,
   output logic [DATA_W-1:0]         data_out,
   output logic                      rx_pop,
   output logic                      credit_ret,
   output logic                      tx_push,
   output logic [DATA_W-1:0]         tx_data,
   output logic                      interrupt
);

   // address hits
   logic              hit_status;
   logic              hit_tx;
   logic              hit_rx;
   logic              hit_ctrl;
   // host strobes
   logic              wr_en;
   logic              rd_en;
   logic              ovr_clr;
   // sticky overrun
   logic              overrun;
   logic [DATA_W-1:0] status;

   assign hit_status = (address == spi_pkg::reg_status);
   assign hit_tx     = (address == spi_pkg::reg_tx);
   assign hit_rx     = (address == spi_pkg::reg_rx);
   assign hit_ctrl   = (address == spi_pkg::reg_ctrl);

   // no handshake, access completes at this edge
   assign wr_en = sel & we;
   assign rd_en = sel & ~we;

   // tx write while full is dropped
   assign tx_push = wr_en & hit_tx & ~tx_full;
   assign tx_data = data_in;

   // only a real pop returns a credit
   assign rx_pop = rd_en & hit_rx & ~rx_empty;

   assign ovr_clr = wr_en & hit_ctrl & data_in[0];

   always_comb begin
      status                        = '0;
      status[spi_pkg::st_rx_valid]  = ~rx_empty;
      status[spi_pkg::st_tx_full]   = tx_full;
      status[spi_pkg::st_overrun]   = overrun;
      status[spi_pkg::st_ss_active] = ss_act;
   end

   // read mux, zero when not selected
   always_comb begin
      data_out = '0;
      if (sel) begin
         if (hit_status) begin
            data_out = status;
         end else if (hit_rx) begin
            // head word during the popping cycle
            data_out = rx_head;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         overrun    <= 1'b0;
         credit_ret <= 1'b0;
      end else begin
         // a new drop beats a clear in the same cycle
         if (rx_drop) begin
            overrun <= 1'b1;
         end else if (ovr_clr) begin
            overrun <= 1'b0;
         end
         // credit goes back one cycle after the pop
         credit_ret <= rx_pop;
      end
   end

   assign interrupt = ~rx_empty | overrun;

endmodule

//--- logic/spi_shift_engine.sv
module spi_shift_engine #(
   parameter int DATA_W   = spi_pkg::data_w,
   parameter int RX_DEPTH = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              sclk_rise,
   input  logic              sclk_fall,
   input  logic              ss_fall,
   input  logic              ss_rise,
   input  logic              ss_act,
   input  logic              mosi_s,
   input  logic [DATA_W-1:0] tx_word,
   input  logic              tx_empty,
   input  logic              credit_ret,
   output logic              miso,
   output logic              rx_push,
   output logic [DATA_W-1:0] rx_word,
   output logic              rx_drop,
   output logic              tx_pop
);

   localparam int CNT_W = (DATA_W > 1) ? $clog2(DATA_W) : 1;
   localparam int CRD_W = $clog2(RX_DEPTH + 1);

   // rising edges seen in the current word
   logic [CNT_W-1:0]  bit_cnt;
   // one cycle after the last rising edge of a word
   logic              word_done;
   // free rx slots the engine may still fill
   logic [CRD_W-1:0]  credits;
   logic [DATA_W-1:0] rx_sr;
   logic [DATA_W-1:0] tx_sr;
   logic              tx_load;

   // new tx word at select and after every full word
   assign tx_load = ss_fall | word_done;
   assign tx_pop  = tx_load & ~tx_empty;

   // push needs a credit, otherwise the word is lost
   assign rx_push = word_done & (credits != '0);
   assign rx_drop = word_done & (credits == '0);
   assign rx_word = rx_sr;

   // lsb first, so miso is always bit 0
   assign miso = tx_sr[0];

   always_ff @(posedge clk) begin
      if (!rst) begin
         bit_cnt   <= '0;
         word_done <= 1'b0;
      end else begin
         word_done <= 1'b0;
         // select edges start a fresh word, partial bits discarded
         if (ss_fall || ss_rise) begin
            bit_cnt <= '0;
         end else if (ss_act && sclk_rise) begin
            if (bit_cnt == CNT_W'(DATA_W - 1)) begin
               bit_cnt   <= '0;
               word_done <= 1'b1;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
      end
   end

   // mode 0 sample on rising sclk, new bit enters at the top
   always_ff @(posedge clk) begin
      if (ss_act && sclk_rise) begin
         rx_sr <= {mosi_s, rx_sr[DATA_W-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         tx_sr <= '0;
      end else if (tx_load) begin
         // underflow sends zeros
         tx_sr <= tx_empty ? '0 : tx_word;
      end else if (ss_act && sclk_fall && bit_cnt != '0) begin
         // no shift on the fall that closes a word, next word already loaded
         tx_sr <= tx_sr >> 1;
      end
   end

   // credit count, push and return may coincide
   always_ff @(posedge clk) begin
      if (!rst) begin
         credits <= CRD_W'(RX_DEPTH);
      end else begin
         case ({rx_push, credit_ret})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

//--- logic/spi_slave_top.sv
module spi_slave_top #(
   parameter int DATA_W   = spi_pkg::data_w,
   parameter int RX_DEPTH = 4,
   parameter int TX_DEPTH = 4
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       sclk,
   input  logic                       ss,
   input  logic                       mosi,
   output logic                       miso,
   input  logic [spi_pkg::addr_w-1:0] address,
   input  logic                       sel,
   input  logic                       we,
   input  logic [DATA_W-1:0]          data_in,
   output logic [DATA_W-1:0]          data_out,
   output logic                       interrupt
);

   // synchronized pin events
   logic sclk_rise, sclk_fall, ss_fall, ss_rise, ss_act, mosi_s;
   // rx path
   logic              rx_push, rx_drop, rx_pop, rx_empty, credit_ret;
   logic [DATA_W-1:0] rx_word, rx_head;
   // tx path
   logic              tx_push, tx_pop, tx_empty, tx_full;
   logic [DATA_W-1:0] tx_data, tx_word;

   spi_pin_sync u_sync (
      .clk(clk), .rst(rst), .sclk(sclk), .ss(ss), .mosi(mosi),
      .sclk_rise(sclk_rise), .sclk_fall(sclk_fall), .ss_fall(ss_fall),
      .ss_rise(ss_rise), .ss_act(ss_act), .mosi_s(mosi_s)
   );

   spi_shift_engine #(.DATA_W(DATA_W), .RX_DEPTH(RX_DEPTH)) u_engine (
      .clk(clk), .rst(rst), .sclk_rise(sclk_rise), .sclk_fall(sclk_fall),
      .ss_fall(ss_fall), .ss_rise(ss_rise), .ss_act(ss_act), .mosi_s(mosi_s),
      .tx_word(tx_word), .tx_empty(tx_empty), .credit_ret(credit_ret),
      .miso(miso), .rx_push(rx_push), .rx_word(rx_word), .rx_drop(rx_drop),
      .tx_pop(tx_pop)
   );

   // credit count keeps the rx fifo from overflowing
   spi_word_fifo #(.item_t(spi_pkg::rx_item_t), .DEPTH(RX_DEPTH)) u_rx (
      .clk(clk), .rst(rst), .push(rx_push), .push_data(rx_word), .pop(rx_pop),
      .head(rx_head), .empty(rx_empty), .full()
   );

   spi_word_fifo #(.item_t(spi_pkg::tx_item_t), .DEPTH(TX_DEPTH)) u_tx (
      .clk(clk), .rst(rst), .push(tx_push), .push_data(tx_data), .pop(tx_pop),
      .head(tx_word), .empty(tx_empty), .full(tx_full)
   );

   spi_reg_if #(.DATA_W(DATA_W)) u_regs (
      .clk(clk), .rst(rst), .address(address), .sel(sel), .we(we),
      .data_in(data_in), .rx_head(rx_head), .rx_empty(rx_empty),
      .tx_full(tx_full), .ss_act(ss_act), .rx_drop(rx_drop),
      .data_out(data_out), .rx_pop(rx_pop), .credit_ret(credit_ret),
      .tx_push(tx_push), .tx_data(tx_data), .interrupt(interrupt)
   );

endmodule

//--- logic/spi_word_fifo.sv
module spi_word_fifo #(
   parameter type item_t = spi_pkg::rx_item_t,
   parameter int  DEPTH  = 4
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  push,
   input  item_t push_data,
   input  logic  pop,
   output item_t head,
   output logic  empty,
   output logic  full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   item_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(DEPTH));

   // pop on empty and push on full are ignored
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   // head word shown without a read cycle
   assign head = mem[rd_ptr];

   // storage, no reset
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // occupancy holds when both happen
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# build and run the spi slave testbench with verilator, then scan the log
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module spi_tb -f compile.f -o spi_sim \
   > build.log 2>&1 \
   && ./obj_dir/spi_sim > sim.log 2>&1 \
   || { cat build.log; echo "Test FAILED" >> sim.log; }

cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

//--- sim/spi_chk.sv
module spi_chk #(
   parameter int RX_DEPTH = 4
) (
   input logic                          clk,
   input logic                          rst,
   input logic [$clog2(RX_DEPTH+1)-1:0] credits,
   input logic                          sclk_rise,
   input logic                          ss_act,
   input logic                          rx_push,
   input logic                          rx_drop,
   input logic                          tx_pop
);

   // returns never outnumber pops
   credit_max: assert property (@(posedge clk) disable iff (!rst)
      int'(credits) <= RX_DEPTH)
      else $error("credit count above rx depth");

   // a word closes one cycle after its last rising sclk pulse
   word_end_timing: assert property (@(posedge clk) disable iff (!rst)
      (rx_push || rx_drop) |-> $past(sclk_rise && ss_act))
      else $error("word end without a rising sclk pulse one cycle before");

   // tx words are taken only while selected
   tx_pop_selected: assert property (@(posedge clk) disable iff (!rst)
      tx_pop |-> ss_act)
      else $error("tx pop while slave select is inactive");

endmodule

bind spi_shift_engine spi_chk #(.RX_DEPTH(RX_DEPTH)) u_chk (
   .clk(clk), .rst(rst), .credits(credits), .sclk_rise(sclk_rise),
   .ss_act(ss_act), .rx_push(rx_push), .rx_drop(rx_drop), .tx_pop(tx_pop)
);

//--- sim/spi_tb.sv
// free running clock for the testbench
module spi_tb_clk #(
   parameter int PERIOD = 20
) (
   output logic clk
);

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

endmodule

module spi_tb;

   localparam int DATA_W    = spi_pkg::data_w;
   localparam int RX_DEPTH  = 4;
   localparam int TX_DEPTH  = 4;
   // clk cycles per sclk half period, select setup and idle gap
   localparam int HALF      = 8;
   localparam int IDLE      = 16;
   localparam int RX_FRAMES = 6;

   // length of one frame carrying n_bits
   function automatic int frame_cycles(int n_bits);
      return HALF + n_bits * 2 * HALF + HALF + IDLE;
   endfunction

   // receive, transmit, overrun, status and partial frames summed
   localparam int FRAME_SUM = RX_FRAMES * frame_cycles(RX_DEPTH * DATA_W)
      + (TX_DEPTH + 1) * frame_cycles(TX_DEPTH * DATA_W)
      + frame_cycles((RX_DEPTH + 2) * DATA_W)
      + frame_cycles(TX_DEPTH * DATA_W)
      + frame_cycles(DATA_W - 1) + frame_cycles(DATA_W);
   localparam int LIMIT = 3 * FRAME_SUM + 2000;

   logic                       clk;
   logic                       rst;
   logic                       sclk;
   logic                       ss;
   logic                       mosi;
   logic                       miso;
   logic [spi_pkg::addr_w-1:0] address;
   logic                       sel;
   logic                       we;
   logic [DATA_W-1:0]          data_in;
   logic [DATA_W-1:0]          data_out;
   logic                       interrupt;
   int                         test_id;
   int                         errors;
   int                         checks;
   int                         cycles = 0;
   integer                     seed;

   spi_tb_clk #(.PERIOD(20)) u_clk (.clk(clk));

   spi_slave_top #(.DATA_W(DATA_W), .RX_DEPTH(RX_DEPTH), .TX_DEPTH(TX_DEPTH)) DUT (
      .clk(clk), .rst(rst), .sclk(sclk), .ss(ss), .mosi(mosi), .miso(miso),
      .address(address), .sel(sel), .we(we), .data_in(data_in),
      .data_out(data_out), .interrupt(interrupt)
   );

   spi_tb_monitor #(.DATA_W(DATA_W), .RX_DEPTH(RX_DEPTH), .TX_DEPTH(TX_DEPTH)) u_mon (
      .clk(clk), .rst(rst), .sclk(sclk), .ss(ss), .mosi(mosi), .miso(miso),
      .address(address), .sel(sel), .we(we), .data_in(data_in),
      .data_out(data_out), .interrupt(interrupt), .test_id(test_id),
      .errors(errors), .checks(checks)
   );

   function automatic logic [DATA_W-1:0] rand_word();
      int r;
      r = $random(seed);
      return r[DATA_W-1:0];
   endfunction

   // uniform-ish value in 0 .. n-1
   function automatic int rand_below(int n);
      int r;
      r = $random(seed);
      return int'({1'b0, r[30:0]}) % n;
   endfunction

   task automatic wait_cycles(int n);
      repeat (n) @(posedge clk);
   endtask

   // one-cycle write, no handshake
   task automatic bus_write(input logic [spi_pkg::addr_w-1:0] addr,
                            input logic [DATA_W-1:0] data);
      @(posedge clk);
      address <= addr;
      data_in <= data;
      sel     <= 1'b1;
      we      <= 1'b1;
      @(posedge clk);
      sel     <= 1'b0;
      we      <= 1'b0;
   endtask

   // data_out taken mid cycle, rx pop lands on the closing edge
   task automatic bus_read(input logic [spi_pkg::addr_w-1:0] addr,
                           output logic [DATA_W-1:0] data);
      @(posedge clk);
      address <= addr;
      sel     <= 1'b1;
      we      <= 1'b0;
      @(negedge clk);
      data = data_out;
      @(posedge clk);
      sel     <= 1'b0;
   endtask

   task automatic peek_status();
      logic [DATA_W-1:0] st;
      bus_read(spi_pkg::reg_status, st);
   endtask

   // pop rx while status says a word is there
   task automatic drain_rx();
      logic [DATA_W-1:0] st;
      logic [DATA_W-1:0] word;
      int                guard;
      guard = 0;
      bus_read(spi_pkg::reg_status, st);
      while (st[spi_pkg::st_rx_valid] && guard < RX_DEPTH + 2) begin
         bus_read(spi_pkg::reg_rx, word);
         bus_read(spi_pkg::reg_status, st);
         guard++;
      end
   endtask

   task automatic frame_begin();
      @(posedge clk);
      ss <= 1'b0;
      wait_cycles(HALF);
   endtask

   // mode 0, lsb first, mosi settles a half period before each rise
   task automatic send_bits(input logic [DATA_W-1:0] w, input int n);
      for (int i = 0; i < n; i++) begin
         mosi <= w[i];
         wait_cycles(HALF);
         sclk <= 1'b1;
         wait_cycles(HALF);
         sclk <= 1'b0;
      end
   endtask

   task automatic frame_end();
      wait_cycles(HALF);
      ss <= 1'b1;
      wait_cycles(IDLE);
   endtask

   task automatic send_random_frame(int n_words);
      frame_begin();
      repeat (n_words) send_bits(rand_word(), DATA_W);
      frame_end();
   endtask

   initial begin
      rst     = 1'b0;
      sclk    = 1'b0;
      ss      = 1'b1;
      mosi    = 1'b0;
      address = '0;
      sel     = 1'b0;
      we      = 1'b0;
      data_in = '0;
      test_id = 0;
      seed    = 32'h8ecf_e5fb;
      wait_cycles(4);
      rst <= 1'b1;
      wait_cycles(2);

      // frames of 1 to RX_DEPTH words, then read them back
      test_id <= 1;
      repeat (RX_FRAMES) begin
         send_random_frame(1 + rand_below(RX_DEPTH));
         drain_rx();
      end

      // 0 to TX_DEPTH queued words, zeros after them
      test_id <= 2;
      for (int k = 0; k <= TX_DEPTH; k++) begin
         repeat (k) bus_write(spi_pkg::reg_tx, rand_word());
         send_random_frame(TX_DEPTH);
         drain_rx();
      end

      // two words past the credits are lost
      test_id <= 3;
      send_random_frame(RX_DEPTH + 2);
      peek_status();
      drain_rx();
      bus_write(spi_pkg::reg_ctrl, DATA_W'(1));
      peek_status();

      // tx full, ignored write, select flag inside and after a frame
      test_id <= 4;
      repeat (TX_DEPTH) bus_write(spi_pkg::reg_tx, rand_word());
      peek_status();
      bus_write(spi_pkg::reg_tx, rand_word());
      peek_status();
      frame_begin();
      peek_status();
      repeat (TX_DEPTH) send_bits(rand_word(), DATA_W);
      frame_end();
      peek_status();
      drain_rx();

      // aborted word, then one full word
      test_id <= 5;
      frame_begin();
      send_bits(rand_word(), 1 + rand_below(DATA_W - 1));
      frame_end();
      peek_status();
      send_random_frame(1);
      drain_rx();

      wait_cycles(4);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // run limit from the summed frame length
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout, the run did not finish within %0d cycles", LIMIT);
         $display("Test FAILED");
         $finish;
      end
   end

endmodule

//--- sim/spi_tb_monitor.sv
module spi_tb_monitor #(
   parameter int DATA_W   = spi_pkg::data_w,
   parameter int RX_DEPTH = 4,
   parameter int TX_DEPTH = 4
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       sclk,
   input  logic                       ss,
   input  logic                       mosi,
   input  logic                       miso,
   input  logic [spi_pkg::addr_w-1:0] address,
   input  logic                       sel,
   input  logic                       we,
   input  logic [DATA_W-1:0]          data_in,
   input  logic [DATA_W-1:0]          data_out,
   input  logic                       interrupt,
   input  int                         test_id,
   output int                         errors,
   output int                         checks
);

   // reference queues for both fifos
   logic [DATA_W-1:0] rx_model [$];
   logic [DATA_W-1:0] tx_model [$];
   // word the slave should be shifting out
   logic [DATA_W-1:0] tx_cur;
   logic [DATA_W-1:0] mosi_word;
   logic [DATA_W-1:0] miso_word;
   logic [DATA_W-1:0] exp_status;
   logic              overrun_model;
   logic              sclk_prev;
   logic              ss_prev;
   int                bit_n;

   function automatic string test_label(int id);
      case (id)
         1:       return "receive";
         2:       return "transmit";
         3:       return "overrun";
         4:       return "status";
         5:       return "partial";
         default: return "idle";
      endcase
   endfunction

   task automatic compare_word(input string what, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERROR %s %s expected %h actual %h", test_label(test_id), what, exp, act);
      end
   endtask

   // slave loads at select and after each full word, zeros on underflow
   task automatic take_tx();
      if (tx_model.size() > 0) begin
         tx_cur = tx_model.pop_front();
      end else begin
         tx_cur = '0;
      end
   endtask

   // pins and bus sampled at the edge, all stable by then
   always @(posedge clk) begin
      if (!rst) begin
         rx_model.delete();
         tx_model.delete();
         tx_cur        = '0;
         mosi_word     = '0;
         miso_word     = '0;
         overrun_model = 1'b0;
         sclk_prev     = 1'b0;
         ss_prev       = 1'b1;
         bit_n         = 0;
         errors        = 0;
         checks        = 0;
      end else begin
         if (ss_prev && !ss) begin
            bit_n = 0;
            take_tx();
         end
         // mode 0 bit on each rising sclk while selected
         if (!ss && sclk && !sclk_prev) begin
            mosi_word = {mosi, mosi_word[DATA_W-1:1]};
            miso_word = {miso, miso_word[DATA_W-1:1]};
            bit_n++;
            if (bit_n == DATA_W) begin
               bit_n = 0;
               compare_word("miso word", tx_cur, miso_word);
               take_tx();
               // a free slot is a credit
               if (rx_model.size() < RX_DEPTH) begin
                  rx_model.push_back(mosi_word);
               end else begin
                  overrun_model = 1'b1;
               end
            end
         end
         // partial bits thrown away
         if (!ss_prev && ss) begin
            bit_n = 0;
         end
         if (sel && we) begin
            if (address == spi_pkg::reg_tx && tx_model.size() < TX_DEPTH) begin
               tx_model.push_back(data_in);
            end
            if (address == spi_pkg::reg_ctrl && data_in[0]) begin
               overrun_model = 1'b0;
            end
         end else if (sel && !we) begin
            if (address == spi_pkg::reg_status) begin
               exp_status                        = '0;
               exp_status[spi_pkg::st_rx_valid]  = (rx_model.size() > 0);
               exp_status[spi_pkg::st_tx_full]   = (tx_model.size() == TX_DEPTH);
               exp_status[spi_pkg::st_overrun]   = overrun_model;
               exp_status[spi_pkg::st_ss_active] = ~ss;
               compare_word("status", exp_status, data_out);
               compare_word("interrupt",
                            DATA_W'((rx_model.size() > 0) | overrun_model),
                            DATA_W'(interrupt));
            end else if (address == spi_pkg::reg_rx && rx_model.size() > 0) begin
               compare_word("rx word", rx_model.pop_front(), data_out);
            end
         end
         sclk_prev = sclk;
         ss_prev   = ss;
      end
   end

endmodule
